/* verilog/cache_config.svh */
`ifndef CACHE_CONFIG_SVH
`define CACHE_CONFIG_SVH

// Bank geometry
`define CACHE_WAYS 4
`define CACHE_SETS 4
`define LINE_BYTES 16
`define TAG_BITS 8
`define PADDR_BITS 15

// Field positions and widths inside a physical address
`define WAY_BITS 2
`define INDEX_BITS 2
`define INDEX_LSB 5
`define TAG_LSB 7
`define LINE_ADDR_BITS (`TAG_BITS + `INDEX_BITS)

// Outstanding misses per bank
`define MSHR_DEPTH 2

`endif

/* verilog/cache_pkg.sv */
`include "cache_config.svh"

package cache_pkg;

  typedef enum logic {
    OP_LOAD,
    OP_STORE
  } cache_op_e;

  // What the bank does with this cycle
  typedef enum logic [2:0] {
    ACC_IDLE,
    ACC_FILL,
    ACC_HIT,
    ACC_MISS,
    ACC_UNCACHED,
    ACC_STALL_MSHR,
    ACC_STALL_SER,
    ACC_STALL_FILL
  } access_kind_e;

  typedef logic [`LINE_BYTES*8-1:0] line_t;

  // Byte-wise merge of store data into a line
  function automatic line_t merge_line(line_t old_line, line_t new_data,
                                       logic [`LINE_BYTES-1:0] mask);
    line_t merged;
    merged = old_line;
    for (int b = 0; b < `LINE_BYTES; b++) begin
      if (mask[b]) begin
        merged[b*8 +: 8] = new_data[b*8 +: 8];
      end
    end
    return merged;
  endfunction

endpackage

/* verilog/cache_bank_if.sv */
`timescale 1ns/1ps
`include "cache_config.svh"

// Controller to tag array
interface tag_lookup_if;
  logic [`PADDR_BITS-1:0] lookup_addr;
  logic                   hit_touch;
  logic                   store_dirty;
  logic                   reserve;
  logic                   fill;
  logic [`PADDR_BITS-1:0] fill_addr;
  logic [`WAY_BITS-1:0]   fill_way;
  logic                   hit;
  logic [`WAY_BITS-1:0]   hit_way;
  logic [`WAY_BITS-1:0]   victim_way;
  logic                   victim_valid;
  logic                   victim_dirty;
  logic [`TAG_BITS-1:0]   victim_tag;
  logic                   no_free_way;

  modport master (
    output lookup_addr, hit_touch, store_dirty, reserve, fill, fill_addr, fill_way,
    input  hit, hit_way, victim_way, victim_valid, victim_dirty, victim_tag, no_free_way
  );
  modport slave (
    input  lookup_addr, hit_touch, store_dirty, reserve, fill, fill_addr, fill_way,
    output hit, hit_way, victim_way, victim_valid, victim_dirty, victim_tag, no_free_way
  );
endinterface

// Controller to miss-status table
interface mshr_if;
  logic                       alloc;
  logic [`LINE_ADDR_BITS-1:0] line_addr;
  logic [`WAY_BITS-1:0]       alloc_way;
  logic                       release_en;
  logic [`LINE_ADDR_BITS-1:0] release_addr;
  logic                       match;
  logic                       full;
  logic [`WAY_BITS-1:0]       release_way;

  modport master (
    output alloc, line_addr, alloc_way, release_en, release_addr,
    input  match, full, release_way
  );
  modport slave (
    input  alloc, line_addr, alloc_way, release_en, release_addr,
    output match, full, release_way
  );
endinterface

/* verilog/cache_tag_array.sv */
`timescale 1ns/1ps
`include "cache_config.svh"

module cache_tag_array (
  input logic         clk,
  input logic         rst,
  tag_lookup_if.slave lookup
);

  logic [`TAG_BITS-1:0]   tag_q     [`CACHE_SETS][`CACHE_WAYS];
  logic [`CACHE_WAYS-1:0] valid_q   [`CACHE_SETS];
  logic [`CACHE_WAYS-1:0] dirty_q   [`CACHE_SETS];
  logic [`CACHE_WAYS-1:0] pending_q [`CACHE_SETS];
  // Age 0 is youngest, CACHE_WAYS-1 oldest
  logic [1:0]             age_q     [`CACHE_SETS][`CACHE_WAYS];

  logic [`INDEX_BITS-1:0] set_idx;
  logic [`TAG_BITS-1:0]   set_tag;
  logic [`INDEX_BITS-1:0] fill_set;
  logic [`WAY_BITS-1:0]   invalid_way;
  logic [`WAY_BITS-1:0]   lru_way;
  logic [`WAY_BITS-1:0]   victim_sel;
  logic [1:0]             lru_age;
  logic                   found_invalid;
  logic                   found_lru;
  logic                   touch_en;
  logic [`INDEX_BITS-1:0] touch_set;
  logic [`WAY_BITS-1:0]   touch_way;

  assign set_idx  = lookup.lookup_addr[`INDEX_LSB +: `INDEX_BITS];
  assign set_tag  = lookup.lookup_addr[`TAG_LSB +: `TAG_BITS];
  assign fill_set = lookup.fill_addr[`INDEX_LSB +: `INDEX_BITS];

  // Tag compare over valid ways
  always_comb begin
    lookup.hit     = 1'b0;
    lookup.hit_way = '0;
    for (int w = 0; w < `CACHE_WAYS; w++) begin
      if (valid_q[set_idx][w] && tag_q[set_idx][w] == set_tag) begin
        lookup.hit     = 1'b1;
        lookup.hit_way = `WAY_BITS'(w);
      end
    end
  end

  // Victim: lowest free way first, then oldest non-pending way
  always_comb begin
    found_invalid = 1'b0;
    invalid_way   = '0;
    for (int w = `CACHE_WAYS-1; w >= 0; w--) begin
      if (!pending_q[set_idx][w] && !valid_q[set_idx][w]) begin
        found_invalid = 1'b1;
        invalid_way   = `WAY_BITS'(w);
      end
    end
    found_lru = 1'b0;
    lru_way   = '0;
    lru_age   = '0;
    for (int w = 0; w < `CACHE_WAYS; w++) begin
      if (!pending_q[set_idx][w] && (!found_lru || age_q[set_idx][w] > lru_age)) begin
        found_lru = 1'b1;
        lru_way   = `WAY_BITS'(w);
        lru_age   = age_q[set_idx][w];
      end
    end
  end

  assign victim_sel          = found_invalid ? invalid_way : lru_way;
  assign lookup.victim_way   = victim_sel;
  assign lookup.victim_valid = valid_q[set_idx][victim_sel];
  assign lookup.victim_dirty = dirty_q[set_idx][victim_sel];
  assign lookup.victim_tag   = tag_q[set_idx][victim_sel];
  assign lookup.no_free_way  = !found_lru;

  assign touch_en  = lookup.hit_touch || lookup.fill;
  assign touch_set = lookup.fill ? fill_set : set_idx;
  assign touch_way = lookup.fill ? lookup.fill_way : lookup.hit_way;

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int s = 0; s < `CACHE_SETS; s++) begin
        valid_q[s]   <= '0;
        dirty_q[s]   <= '0;
        pending_q[s] <= '0;
        for (int w = 0; w < `CACHE_WAYS; w++) begin
          age_q[s][w] <= 2'(`CACHE_WAYS - 1 - w);
        end
      end
    end else begin
      if (lookup.reserve) begin
        valid_q[set_idx][victim_sel]   <= 1'b0;
        dirty_q[set_idx][victim_sel]   <= 1'b0;
        pending_q[set_idx][victim_sel] <= 1'b1;
      end
      if (lookup.store_dirty) begin
        dirty_q[set_idx][lookup.hit_way] <= 1'b1;
      end
      if (lookup.fill) begin
        tag_q[fill_set][lookup.fill_way]     <= lookup.fill_addr[`TAG_LSB +: `TAG_BITS];
        valid_q[fill_set][lookup.fill_way]   <= 1'b1;
        dirty_q[fill_set][lookup.fill_way]   <= 1'b0;
        pending_q[fill_set][lookup.fill_way] <= 1'b0;
      end
      // Touched way becomes youngest, younger ones age by one
      if (touch_en) begin
        for (int w = 0; w < `CACHE_WAYS; w++) begin
          if (`WAY_BITS'(w) == touch_way) begin
            age_q[touch_set][w] <= '0;
          end else if (age_q[touch_set][w] < age_q[touch_set][touch_way]) begin
            age_q[touch_set][w] <= age_q[touch_set][w] + 2'd1;
          end
        end
      end
    end
  end

endmodule

/* verilog/cache_data_array.sv */
`timescale 1ns/1ps
`include "cache_config.svh"

module cache_data_array
  import cache_pkg::*;
(
  input  logic                   clk,
  input  logic [`INDEX_BITS-1:0] index,
  input  logic [`WAY_BITS-1:0]   way,
  input  logic [`LINE_BYTES-1:0] wr_mask,
  input  line_t                  wr_data,
  input  logic                   store_en,
  input  logic                   fill_en,
  output line_t                  rd_line_hit,
  output line_t                  rd_line_victim,
  input  logic [`WAY_BITS-1:0]   hit_way,
  input  logic [`WAY_BITS-1:0]   victim_way
);

  line_t lines_q [`CACHE_SETS][`CACHE_WAYS];

  // Both read ports look at the same set
  assign rd_line_hit    = lines_q[index][hit_way];
  assign rd_line_victim = lines_q[index][victim_way];

  always_ff @(posedge clk) begin
    if (fill_en) begin
      lines_q[index][way] <= wr_data;
    end else if (store_en) begin
      lines_q[index][way] <= merge_line(lines_q[index][way], wr_data, wr_mask);
    end
  end

endmodule

/* verilog/cache_mshr.sv */
`timescale 1ns/1ps
`include "cache_config.svh"

module cache_mshr (
  input logic   clk,
  input logic   rst,
  mshr_if.slave mshr
);

  logic [`MSHR_DEPTH-1:0]     valid_q;
  logic [`LINE_ADDR_BITS-1:0] addr_q [`MSHR_DEPTH];
  logic [`WAY_BITS-1:0]       way_q  [`MSHR_DEPTH];

  logic [`MSHR_DEPTH-1:0] alloc_sel;
  logic [`MSHR_DEPTH-1:0] req_hit;
  logic [`MSHR_DEPTH-1:0] release_hit;

  // Lowest clear bit of the valid vector
  assign alloc_sel = ~valid_q & (valid_q + 1'b1);

  always_comb begin
    mshr.release_way = '0;
    for (int e = 0; e < `MSHR_DEPTH; e++) begin
      req_hit[e]     = valid_q[e] && addr_q[e] == mshr.line_addr;
      release_hit[e] = valid_q[e] && addr_q[e] == mshr.release_addr;
      if (release_hit[e]) begin
        mshr.release_way = way_q[e];
      end
    end
  end

  assign mshr.match = |req_hit;
  assign mshr.full  = &valid_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= '0;
    end else begin
      for (int e = 0; e < `MSHR_DEPTH; e++) begin
        if (mshr.alloc && alloc_sel[e]) begin
          valid_q[e] <= 1'b1;
          addr_q[e]  <= mshr.line_addr;
          way_q[e]   <= mshr.alloc_way;
        end else if (mshr.release_en && release_hit[e]) begin
          valid_q[e] <= 1'b0;
        end
      end
    end
  end

endmodule

/* verilog/cache_access_ctrl.sv */
`timescale 1ns/1ps
`include "cache_config.svh"

module cache_access_ctrl
  import cache_pkg::*;
#(
  parameter int unsigned BANK_ID = 0
) (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   valid_in,
  input  cache_op_e              op,
  input  logic                   pcd,
  input  logic [`PADDR_BITS-1:0] paddr,
  input  line_t                  wdata,
  input  logic [`LINE_BYTES-1:0] wmask,
  input  logic                   fill_valid,
  input  logic [`PADDR_BITS-1:0] fill_paddr,
  input  line_t                  fill_data,
  input  logic                   ser0_full,
  input  logic                   ser1_full,
  tag_lookup_if.master           lookup,
  mshr_if.master                 mshr,
  output logic [`INDEX_BITS-1:0] da_index,
  output logic [`WAY_BITS-1:0]   da_way,
  output logic [`LINE_BYTES-1:0] da_wr_mask,
  output line_t                  da_wr_data,
  output logic                   da_store_en,
  output logic                   da_fill_en,
  input  line_t                  da_hit_line,
  input  line_t                  da_victim_line,
  output logic                   aq_read,
  output logic                   ex_valid,
  output line_t                  ex_data,
  output logic [`PADDR_BITS-1:0] ex_paddr,
  output logic [1:0]             ex_wake,
  output logic                   ser_valid0,
  output line_t                  ser_data0,
  output logic [`PADDR_BITS-1:0] ser_paddr0,
  output logic                   ser_rw0,
  output logic [2:0]             ser_dest0,
  output logic                   ser_valid1,
  output logic [`PADDR_BITS-1:0] ser_paddr1,
  output logic                   ser_dest1,
  output logic                   cache_stall,
  output logic                   cache_miss
);

  // Bank holds the lines whose address bit 4 matches its id
  localparam logic BANK_BIT = (BANK_ID % 2) != 0;

  access_kind_e kind;
  logic         wb_needed;
  logic         is_store;

  assign is_store  = op == OP_STORE;
  assign wb_needed = lookup.victim_valid && lookup.victim_dirty;

  // Fill wins over any request in its cycle
  always_comb begin
    kind = ACC_IDLE;
    if (fill_valid) begin
      kind = valid_in ? ACC_STALL_FILL : ACC_FILL;
    end else if (valid_in) begin
      if (pcd) begin
        kind = ser0_full ? ACC_STALL_SER : ACC_UNCACHED;
      end else if (lookup.hit) begin
        kind = ACC_HIT;
      end else if (mshr.match || mshr.full || lookup.no_free_way) begin
        kind = ACC_STALL_MSHR;
      end else if (ser1_full || (wb_needed && ser0_full)) begin
        kind = ACC_STALL_SER;
      end else begin
        kind = ACC_MISS;
      end
    end
  end

  assign aq_read     = kind == ACC_HIT || kind == ACC_UNCACHED;
  assign cache_stall = valid_in && !aq_read;

  // Tag array updates
  assign lookup.lookup_addr = paddr;
  assign lookup.hit_touch   = kind == ACC_HIT;
  assign lookup.store_dirty = kind == ACC_HIT && is_store;
  assign lookup.reserve     = kind == ACC_MISS;
  assign lookup.fill        = fill_valid;
  assign lookup.fill_addr   = fill_paddr;
  assign lookup.fill_way    = mshr.release_way;

  assign mshr.alloc        = kind == ACC_MISS;
  assign mshr.line_addr    = paddr[`INDEX_LSB +: `LINE_ADDR_BITS];
  assign mshr.alloc_way    = lookup.victim_way;
  assign mshr.release_en   = fill_valid;
  assign mshr.release_addr = fill_paddr[`INDEX_LSB +: `LINE_ADDR_BITS];

  // Data array steered to the fill when one arrives
  assign da_index    = fill_valid ? fill_paddr[`INDEX_LSB +: `INDEX_BITS]
                                  : paddr[`INDEX_LSB +: `INDEX_BITS];
  assign da_way      = fill_valid ? mshr.release_way : lookup.hit_way;
  assign da_wr_data  = fill_valid ? fill_data : wdata;
  assign da_wr_mask  = wmask;
  assign da_store_en = kind == ACC_HIT && is_store;
  assign da_fill_en  = fill_valid;

  always_ff @(posedge clk) begin
    if (rst) begin
      ex_valid   <= 1'b0;
      ser_valid0 <= 1'b0;
      ser_valid1 <= 1'b0;
      cache_miss <= 1'b0;
    end else begin
      ex_valid   <= kind == ACC_HIT;
      ser_valid0 <= (kind == ACC_MISS && wb_needed) || kind == ACC_UNCACHED;
      ser_valid1 <= kind == ACC_MISS;
      cache_miss <= kind == ACC_MISS;
    end
  end

  always_ff @(posedge clk) begin
    if (kind == ACC_HIT) begin
      ex_data  <= is_store ? merge_line(da_hit_line, wdata, wmask) : da_hit_line;
      ex_paddr <= paddr;
      ex_wake  <= is_store ? 2'b10 : 2'b01;
    end
    if (kind == ACC_MISS) begin
      ser_paddr1 <= {paddr[`PADDR_BITS-1:4], 4'b0};
      ser_dest1  <= paddr[4];
      // Victim writeback, only sent out when dirty
      ser_data0  <= da_victim_line;
      ser_paddr0 <= {lookup.victim_tag, paddr[`INDEX_LSB +: `INDEX_BITS], BANK_BIT, 4'b0};
      ser_rw0    <= 1'b1;
      ser_dest0  <= {1'b0, paddr[`INDEX_LSB], 1'b0};
    end else if (kind == ACC_UNCACHED) begin
      ser_data0  <= wdata;
      ser_paddr0 <= paddr;
      ser_rw0    <= is_store;
      ser_dest0  <= 3'b110;
    end
  end

endmodule

/* verilog/cache_bank.sv */
`timescale 1ns/1ps
`include "cache_config.svh"

module cache_bank
  import cache_pkg::*;
#(
  parameter int unsigned BANK_ID = 0
) (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   valid_in,
  input  cache_op_e              op,
  input  logic                   pcd,
  input  logic [`PADDR_BITS-1:0] paddr,
  input  line_t                  wdata,
  input  logic [`LINE_BYTES-1:0] wmask,
  input  logic                   fill_valid,
  input  logic [`PADDR_BITS-1:0] fill_paddr,
  input  line_t                  fill_data,
  input  logic                   ser0_full,
  input  logic                   ser1_full,
  output logic                   aq_read,
  output logic                   ex_valid,
  output line_t                  ex_data,
  output logic [`PADDR_BITS-1:0] ex_paddr,
  output logic [1:0]             ex_wake,
  output logic                   ser_valid0,
  output line_t                  ser_data0,
  output logic [`PADDR_BITS-1:0] ser_paddr0,
  output logic                   ser_rw0,
  output logic [2:0]             ser_dest0,
  output logic                   ser_valid1,
  output logic [`PADDR_BITS-1:0] ser_paddr1,
  output logic                   ser_dest1,
  output logic                   cache_stall,
  output logic                   cache_miss
);

  tag_lookup_if lookup_bus ();
  mshr_if       mshr_bus ();

  logic [`INDEX_BITS-1:0] da_index;
  logic [`WAY_BITS-1:0]   da_way;
  logic [`LINE_BYTES-1:0] da_wr_mask;
  line_t                  da_wr_data;
  logic                   da_store_en;
  logic                   da_fill_en;
  line_t                  da_hit_line;
  line_t                  da_victim_line;

  cache_tag_array u_tags (
    .clk    (clk),
    .rst    (rst),
    .lookup (lookup_bus.slave)
  );

  // Read ways come straight from the tag lookup
  cache_data_array u_data (
    .clk            (clk),
    .index          (da_index),
    .way            (da_way),
    .wr_mask        (da_wr_mask),
    .wr_data        (da_wr_data),
    .store_en       (da_store_en),
    .fill_en        (da_fill_en),
    .rd_line_hit    (da_hit_line),
    .rd_line_victim (da_victim_line),
    .hit_way        (lookup_bus.hit_way),
    .victim_way     (lookup_bus.victim_way)
  );

  cache_mshr u_mshr (
    .clk  (clk),
    .rst  (rst),
    .mshr (mshr_bus.slave)
  );

  cache_access_ctrl #(
    .BANK_ID (BANK_ID)
  ) u_ctrl (
    .clk            (clk),
    .rst            (rst),
    .valid_in       (valid_in),
    .op             (op),
    .pcd            (pcd),
    .paddr          (paddr),
    .wdata          (wdata),
    .wmask          (wmask),
    .fill_valid     (fill_valid),
    .fill_paddr     (fill_paddr),
    .fill_data      (fill_data),
    .ser0_full      (ser0_full),
    .ser1_full      (ser1_full),
    .lookup         (lookup_bus.master),
    .mshr           (mshr_bus.master),
    .da_index       (da_index),
    .da_way         (da_way),
    .da_wr_mask     (da_wr_mask),
    .da_wr_data     (da_wr_data),
    .da_store_en    (da_store_en),
    .da_fill_en     (da_fill_en),
    .da_hit_line    (da_hit_line),
    .da_victim_line (da_victim_line),
    .aq_read        (aq_read),
    .ex_valid       (ex_valid),
    .ex_data        (ex_data),
    .ex_paddr       (ex_paddr),
    .ex_wake        (ex_wake),
    .ser_valid0     (ser_valid0),
    .ser_data0      (ser_data0),
    .ser_paddr0     (ser_paddr0),
    .ser_rw0        (ser_rw0),
    .ser_dest0      (ser_dest0),
    .ser_valid1     (ser_valid1),
    .ser_paddr1     (ser_paddr1),
    .ser_dest1      (ser_dest1),
    .cache_stall    (cache_stall),
    .cache_miss     (cache_miss)
  );

endmodule

/* testbench/cache_bank_sva.sv */
`timescale 1ns/1ps

module cache_bank_sva (
  input logic clk,
  input logic rst,
  input logic valid_in,
  input logic pcd,
  input logic ser0_full,
  input logic ser1_full,
  input logic aq_read,
  input logic ex_valid,
  input logic cache_miss,
  input logic cache_stall,
  input logic ser_valid0,
  input logic ser_valid1
);

  // The queue is popped only for a present request
  pop_needs_request: assert property (@(posedge clk) disable iff (rst)
    aq_read |-> valid_in)
    else $error("aq_read high without valid_in");

  hit_miss_exclusive: assert property (@(posedge clk) disable iff (rst)
    !(ex_valid && cache_miss))
    else $error("ex_valid and cache_miss high together");

  // Serializer stalls leave both ports quiet in the next cycle
  miss_stall_quiet: assert property (@(posedge clk) disable iff (rst)
    valid_in && cache_stall && ser1_full |=> !ser_valid0 && !ser_valid1)
    else $error("serializer strobe after a stall on ser1_full");

  uncached_stall_quiet: assert property (@(posedge clk) disable iff (rst)
    valid_in && pcd && ser0_full |=> !ser_valid0 && !ser_valid1)
    else $error("serializer strobe after an uncached stall on ser0_full");

endmodule

bind cache_bank cache_bank_sva u_sva (
  .clk         (clk),
  .rst         (rst),
  .valid_in    (valid_in),
  .pcd         (pcd),
  .ser0_full   (ser0_full),
  .ser1_full   (ser1_full),
  .aq_read     (aq_read),
  .ex_valid    (ex_valid),
  .cache_miss  (cache_miss),
  .cache_stall (cache_stall),
  .ser_valid0  (ser_valid0),
  .ser_valid1  (ser_valid1)
);

/* testbench/cache_bank_tb.sv */
`timescale 1ns/1ps
`include "cache_config.svh"

module cache_bank_tb
  import cache_pkg::*;
();

  localparam int          TIMEOUT    = 200;
  localparam int          FILL_DELAY = 4;
  localparam logic [31:0] SEED       = 32'h84e3_9da6;

  logic                   clk;
  logic                   rst;
  logic                   valid_in;
  cache_op_e              op;
  logic                   pcd;
  logic [`PADDR_BITS-1:0] paddr;
  line_t                  wdata;
  logic [`LINE_BYTES-1:0] wmask;
  logic                   fill_valid;
  logic [`PADDR_BITS-1:0] fill_paddr;
  line_t                  fill_data;
  logic                   ser0_full;
  logic                   ser1_full;
  logic                   aq_read;
  logic                   ex_valid;
  line_t                  ex_data;
  logic [`PADDR_BITS-1:0] ex_paddr;
  logic [1:0]             ex_wake;
  logic                   ser_valid0;
  line_t                  ser_data0;
  logic [`PADDR_BITS-1:0] ser_paddr0;
  logic                   ser_rw0;
  logic [2:0]             ser_dest0;
  logic                   ser_valid1;
  logic [`PADDR_BITS-1:0] ser_paddr1;
  logic                   ser_dest1;
  logic                   cache_stall;
  logic                   cache_miss;

  // Expected line contents, keyed by line address
  line_t                  model [logic [`PADDR_BITS-1:0]];
  logic [`PADDR_BITS-1:0] fill_addr_q [$];
  int                     fill_due_q [$];
  logic                   send_fill;
  logic                   hold_fills;
  int                     cycle_cnt;
  int                     tests;
  int                     checks;
  int                     errors;
  int                     err_start;
  string                  cur_test;

  cache_bank #(.BANK_ID(0)) UUT (.*);

  initial clk = 1'b0;
  always #5 clk = ~clk;

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Memory contents seen by a fill, four words per line
  function automatic line_t fill_pattern(input logic [`PADDR_BITS-1:0] line_addr);
    logic [31:0] s;
    line_t       l;
    s = SEED ^ {17'b0, line_addr};
    for (int i = 0; i < 4; i++) begin
      s = xorshift(s);
      l[i*32 +: 32] = s;
    end
    return l;
  endfunction

  function automatic logic [`PADDR_BITS-1:0] mk_addr(input logic [7:0] tag,
                                                     input logic [1:0] set);
    return {tag, set, 1'b0, 4'h0};
  endfunction

  function automatic logic [`PADDR_BITS-1:0] line_of(input logic [`PADDR_BITS-1:0] a);
    return {a[`PADDR_BITS-1:4], 4'h0};
  endfunction

  function automatic line_t expected_line(input logic [`PADDR_BITS-1:0] a);
    if (model.exists(line_of(a))) begin
      return model[line_of(a)];
    end
    return fill_pattern(line_of(a));
  endfunction

  // Masked bytes come from the store, the rest stay
  function automatic line_t apply_store(input line_t old_line, input line_t data,
                                        input logic [`LINE_BYTES-1:0] mask);
    line_t res;
    res = old_line;
    for (int b = 0; b < `LINE_BYTES; b++) begin
      if (mask[b]) begin
        res[b*8 +: 8] = data[b*8 +: 8];
      end
    end
    return res;
  endfunction

  // Memory stub answering fill requests from port 1
  always @(posedge clk) begin
    if (ser_valid1 && !rst) begin
      fill_addr_q.push_back(ser_paddr1);
      fill_due_q.push_back(cycle_cnt + FILL_DELAY);
    end
    send_fill = !hold_fills && fill_due_q.size() > 0 && fill_due_q[0] <= cycle_cnt;
    #1;
    fill_valid = 1'b0;
    if (send_fill) begin
      fill_valid = 1'b1;
      fill_paddr = fill_addr_q.pop_front();
      void'(fill_due_q.pop_front());
      fill_data  = fill_pattern(fill_paddr);
    end
  end

  task automatic check_val(input string name, input logic [127:0] expected,
                           input logic [127:0] actual);
    checks++;
    assert (actual === expected) else begin
      $display("[FAIL] %s expected %0h actual %0h", name, expected, actual);
      errors++;
    end
  endtask

  task automatic abort_on_timeout(input string what);
    $display("Timeout while waiting for %s in test %s", what, cur_test);
    $display("*** TEST FAILED ***");
    $finish;
  endtask

  task automatic start_test(input string name);
    cur_test  = name;
    err_start = errors;
  endtask

  task automatic end_test();
    tests++;
    $display("Test %s finished with %0d errors", cur_test, errors - err_start);
  endtask

  task automatic drive_req(input cache_op_e o, input logic p,
                           input logic [`PADDR_BITS-1:0] a, input line_t d,
                           input logic [`LINE_BYTES-1:0] m);
    valid_in = 1'b1;
    op       = o;
    pcd      = p;
    paddr    = a;
    wdata    = d;
    wmask    = m;
  endtask

  // Holds the request until the queue pop, checking the stall on the way
  task automatic wait_pop();
    int   n;
    logic popped;
    n      = 0;
    popped = 1'b0;
    while (!popped) begin
      @(negedge clk);
      popped = aq_read;
      if (!popped) begin
        check_val({cur_test, " cache_stall"}, 1'b1, cache_stall);
      end
      @(posedge clk);
      #1;
      n++;
      // A stalled retry must not send a second fill request
      if (!popped) begin
        check_val({cur_test, " ser_valid1 while stalled"}, 1'b0, ser_valid1);
      end
      if (!popped && n > TIMEOUT) begin
        abort_on_timeout("the request to be popped");
      end
    end
    valid_in = 1'b0;
  endtask

  task automatic wait_miss(input logic [`PADDR_BITS-1:0] a, input logic wb,
                           input logic [`PADDR_BITS-1:0] wb_addr, input line_t wb_data);
    int n;
    n = 0;
    do begin
      @(posedge clk);
      #1;
      n++;
      if (n > TIMEOUT) begin
        abort_on_timeout("cache_miss");
      end
    end while (!cache_miss);
    check_val({cur_test, " ser_valid1"}, 1'b1, ser_valid1);
    check_val({cur_test, " ser_paddr1"}, line_of(a), ser_paddr1);
    check_val({cur_test, " ser_dest1"}, a[4], ser_dest1);
    check_val({cur_test, " ser_valid0"}, wb, ser_valid0);
    if (wb) begin
      check_val({cur_test, " ser_data0"}, wb_data, ser_data0);
      check_val({cur_test, " ser_paddr0"}, wb_addr, ser_paddr0);
      check_val({cur_test, " ser_rw0"}, 1'b1, ser_rw0);
      check_val({cur_test, " ser_dest0"}, {1'b0, a[5], 1'b0}, ser_dest0);
    end
  endtask

  task automatic check_ex(input logic [`PADDR_BITS-1:0] a, input line_t exp_line,
                          input logic [1:0] wake);
    check_val({cur_test, " ex_valid"}, 1'b1, ex_valid);
    check_val({cur_test, " ex_data"}, exp_line, ex_data);
    check_val({cur_test, " ex_wake"}, wake, ex_wake);
    check_val({cur_test, " ex_paddr"}, a, ex_paddr);
  endtask

  task automatic finish_load(input logic [`PADDR_BITS-1:0] a);
    wait_pop();
    check_ex(a, expected_line(a), 2'b01);
    model[line_of(a)] = expected_line(a);
  endtask

  task automatic miss_load(input logic [`PADDR_BITS-1:0] a, input logic wb,
                           input logic [`PADDR_BITS-1:0] wb_addr, input line_t wb_data);
    drive_req(OP_LOAD, 1'b0, a, '0, '0);
    wait_miss(a, wb, wb_addr, wb_data);
    finish_load(a);
  endtask

  task automatic hit_access(input cache_op_e o, input logic [`PADDR_BITS-1:0] a,
                            input line_t d, input logic [`LINE_BYTES-1:0] m);
    line_t exp_line;
    exp_line = expected_line(a);
    if (o == OP_STORE) begin
      exp_line = apply_store(exp_line, d, m);
    end
    drive_req(o, 1'b0, a, d, m);
    wait_pop();
    check_ex(a, exp_line, o == OP_STORE ? 2'b10 : 2'b01);
    model[line_of(a)] = exp_line;
  endtask

  initial begin
    line_t                  ud;
    logic [`PADDR_BITS-1:0] ua;
    logic [`PADDR_BITS-1:0] a6;
    valid_in   = 1'b0;
    op         = OP_LOAD;
    pcd        = 1'b0;
    paddr      = '0;
    wdata      = '0;
    wmask      = '0;
    fill_valid = 1'b0;
    fill_paddr = '0;
    fill_data  = '0;
    ser0_full  = 1'b0;
    ser1_full  = 1'b0;
    hold_fills = 1'b0;
    cycle_cnt  = 0;
    tests      = 0;
    checks     = 0;
    errors     = 0;
    rst        = 1'b1;
    repeat (10) @(posedge clk);
    #1;
    rst = 1'b0;

    start_test("cold_load");
    miss_load(mk_addr(8'h11, 2'd0), 1'b0, '0, '0);
    end_test();

    start_test("store_hit");
    hit_access(OP_STORE, mk_addr(8'h11, 2'd0) | 15'h3, {4{32'hdead_beef}}, 16'h0ff0);
    hit_access(OP_LOAD, mk_addr(8'h11, 2'd0), '0, '0);
    end_test();

    // Fill set 1, dirty way 0, then make it the oldest
    start_test("dirty_evict");
    for (int t = 0; t < 4; t++) begin
      miss_load(mk_addr(8'(8'h21 + t), 2'd1), 1'b0, '0, '0);
    end
    hit_access(OP_STORE, mk_addr(8'h21, 2'd1), {4{32'h0bad_cafe}}, 16'hf00f);
    for (int t = 1; t < 4; t++) begin
      hit_access(OP_LOAD, mk_addr(8'(8'h21 + t), 2'd1), '0, '0);
    end
    miss_load(mk_addr(8'h25, 2'd1), 1'b1, mk_addr(8'h21, 2'd1),
              model[mk_addr(8'h21, 2'd1)]);
    model.delete(mk_addr(8'h21, 2'd1));
    end_test();

    // Two misses fill the MSHR while fills are held back
    start_test("miss_limits");
    hold_fills = 1'b1;
    drive_req(OP_LOAD, 1'b0, mk_addr(8'h31, 2'd2), '0, '0);
    wait_miss(mk_addr(8'h31, 2'd2), 1'b0, '0, '0);
    valid_in = 1'b0;
    drive_req(OP_LOAD, 1'b0, mk_addr(8'h32, 2'd2), '0, '0);
    wait_miss(mk_addr(8'h32, 2'd2), 1'b0, '0, '0);
    valid_in = 1'b0;
    drive_req(OP_LOAD, 1'b0, mk_addr(8'h33, 2'd2), '0, '0);
    repeat (8) begin
      @(negedge clk);
      check_val({cur_test, " cache_stall"}, 1'b1, cache_stall);
      @(posedge clk);
      #1;
      check_val({cur_test, " ser_valid1 while full"}, 1'b0, ser_valid1);
    end
    hold_fills = 1'b0;
    wait_miss(mk_addr(8'h33, 2'd2), 1'b0, '0, '0);
    // Same request now waits on its own pending line
    finish_load(mk_addr(8'h33, 2'd2));
    hit_access(OP_LOAD, mk_addr(8'h31, 2'd2), '0, '0);
    hit_access(OP_LOAD, mk_addr(8'h32, 2'd2), '0, '0);
    end_test();

    start_test("uncached");
    ud        = {4{32'h1234_5678}};
    ua        = 15'h5a34;
    ser0_full = 1'b1;
    drive_req(OP_STORE, 1'b1, ua, ud, 16'hffff);
    // Port 0 full holds the uncached request back
    repeat (3) begin
      @(negedge clk);
      check_val({cur_test, " cache_stall"}, 1'b1, cache_stall);
      @(posedge clk);
      #1;
      check_val({cur_test, " ser_valid0 while full"}, 1'b0, ser_valid0);
    end
    ser0_full = 1'b0;
    wait_pop();
    check_val({cur_test, " ser_valid0"}, 1'b1, ser_valid0);
    check_val({cur_test, " ser_data0"}, ud, ser_data0);
    check_val({cur_test, " ser_paddr0"}, ua, ser_paddr0);
    check_val({cur_test, " ser_rw0"}, 1'b1, ser_rw0);
    check_val({cur_test, " ser_dest0"}, 3'b110, ser_dest0);
    check_val({cur_test, " ex_valid"}, 1'b0, ex_valid);
    end_test();

    // Upper half-line address, so the fill goes to the other destination
    start_test("back_pressure");
    a6        = mk_addr(8'h51, 2'd3) | 15'h10;
    ser1_full = 1'b1;
    drive_req(OP_LOAD, 1'b0, a6, '0, '0);
    repeat (5) begin
      @(negedge clk);
      check_val({cur_test, " cache_stall"}, 1'b1, cache_stall);
      @(posedge clk);
      #1;
      check_val({cur_test, " ser_valid1"}, 1'b0, ser_valid1);
      check_val({cur_test, " ser_valid0"}, 1'b0, ser_valid0);
      check_val({cur_test, " cache_miss"}, 1'b0, cache_miss);
    end
    ser1_full = 1'b0;
    wait_miss(a6, 1'b0, '0, '0);
    finish_load(a6);
    end_test();

    $display("Tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

/* sim.f */
+incdir+verilog
verilog/cache_pkg.sv
verilog/cache_bank_if.sv
verilog/cache_tag_array.sv
verilog/cache_data_array.sv
verilog/cache_mshr.sv
verilog/cache_access_ctrl.sv
verilog/cache_bank.sv
testbench/cache_bank_sva.sv
testbench/cache_bank_tb.sv

/* Bender.yml */
package:
  name: cache_bank

export_include_dirs:
  - verilog

sources:
  - verilog/cache_pkg.sv
  - verilog/cache_bank_if.sv
  - verilog/cache_tag_array.sv
  - verilog/cache_data_array.sv
  - verilog/cache_mshr.sv
  - verilog/cache_access_ctrl.sv
  - verilog/cache_bank.sv
  - target: test
    files:
      - testbench/cache_bank_sva.sv
      - testbench/cache_bank_tb.sv
